// File: frontend_input.txt
// Frontend commands, three hex words per line: opcode arg1 arg2
// 1 ack delay (ffffffff random), 2 wait, 3 commit, 4 flush id pc, 5 expect n quiet, 0 end
1 0 0
5 7 14
3 2 0
5 2 14
1 c 0
3 3 0
5 3 14
4 7 2000
5 4 14
3 3 0
5 1 0
2 4 0
4 4 3008
5 2 14
1 ffffffff 0
3 5 0
5 5 14
3 7 0
5 3 0
4 6 400c
5 4 14
0 0 0

// File: run.sh
#!/bin/sh
# Build the frontend testbench with Verilator, run it, judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_frontend -o tb_frontend \
    && ./obj_dir/tb_frontend > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"

// File: project.f
frontend_pkg.sv
block_predictor.sv
ftq.sv
fetch_unit.sv
frontend_top.sv
tb_frontend.sv

// File: tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
    import frontend_pkg::*;

    localparam int MAX_CMDS = 64;

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    logic                    flush_i = 1'b0;
    logic [FTQ_ID_W-1:0]     flush_id_i = '0;
    logic [ADDR_W-1:0]       flush_pc_i = '0;
    logic [COMMIT_WIDTH-1:0] commit_i = '0;
    logic                    imem_req_o;
    logic [ADDR_W-1:0]       imem_addr_o;
    logic                    imem_ack_i = 1'b0;
    logic                    fetch_valid_o;
    logic [ADDR_W-1:0]       fetch_pc_o;
    logic [LEN_W-1:0]        fetch_length_o;
    logic [FTQ_ID_W-1:0]     fetch_id_o;

    // Command script, three words per command
    logic [31:0] script [0:3*MAX_CMDS-1];
    int          script_lines = 0;
    int          run_limit = 0;
    int          ack_delay = 0;
    integer      seed = 32'h79a3_e49a;
    int          mismatches = 0;
    int          errors = 0;
    int          fetch_count = 0;

    // Reference model of the fetch stream
    logic [ADDR_W-1:0]   exp_pc = RESET_PC;
    logic [FTQ_ID_W-1:0] exp_id = '0;
    logic [FTQ_ID_W-1:0] commit_id = '0;
    logic [FTQ_ID_W-1:0] outstanding [$];

    logic              prev_req = 1'b0;
    logic [ADDR_W-1:0] req_addr = '0;
    int                req_cycles = 0;
    int                cur_delay = 0;
    int                release_delay = 0;

    frontend_top UUT (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .flush_id_i     (flush_id_i),
        .flush_pc_i     (flush_pc_i),
        .commit_i       (commit_i),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .imem_ack_i     (imem_ack_i),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_pc_o     (fetch_pc_o),
        .fetch_length_o (fetch_length_o),
        .fetch_id_o     (fetch_id_o)
    );

    always #50 clk = ~clk;

    // Instructions left until the next 16-byte boundary
    function automatic logic [LEN_W-1:0] block_len(input logic [ADDR_W-1:0] pc);
        int bytes_left;
        bytes_left = BLOCK_BYTES - int'(pc % BLOCK_BYTES);
        return LEN_W'(bytes_left / 4);
    endfunction

    task automatic check_fetch();
        logic [LEN_W-1:0] exp_len;
        exp_len = block_len(exp_pc);
        if (fetch_pc_o !== exp_pc || fetch_length_o !== exp_len || fetch_id_o !== exp_id) begin
            mismatches++;
            $display("mismatch at %0t: fetch pc %h len %0d id %0d, expected pc %h len %0d id %0d",
                     $time, fetch_pc_o, fetch_length_o, fetch_id_o, exp_pc, exp_len, exp_id);
        end
        // Address that went out to memory for this block
        if (req_addr !== exp_pc) begin
            mismatches++;
            $display("mismatch at %0t: request address %h, expected %h",
                     $time, req_addr, exp_pc);
        end
        if (outstanding.size() >= FTQ_SIZE - 1) begin
            errors++;
            $display("Fetch at %0t goes beyond the %0d blocks the queue can hold",
                     $time, FTQ_SIZE - 1);
        end
        outstanding.push_back(fetch_id_o);
        exp_pc = exp_pc + ADDR_W'(exp_len) * 4;
        exp_id = exp_id + 1'b1;
        fetch_count++;
    endtask

    // Instruction memory, four-phase ack after a programmable latency
    always @(posedge clk) begin
        if (rst) begin
            imem_ack_i <= 1'b0;
            req_cycles = 0;
        end else if (imem_ack_i) begin
            if (!imem_req_o) begin
                // Random mode also holds ack a few cycles after req falls
                if (req_cycles >= release_delay) begin
                    imem_ack_i <= 1'b0;
                    req_cycles = 0;
                end else begin
                    req_cycles++;
                end
            end
        end else if (imem_req_o) begin
            if (req_cycles == 0) begin
                cur_delay = (ack_delay < 0) ? ($random(seed) & 7) : ack_delay;
                release_delay = (ack_delay < 0) ? ($random(seed) & 3) : 0;
            end
            if (req_cycles >= cur_delay) begin
                imem_ack_i <= 1'b1;
                req_cycles = 0;
            end else begin
                req_cycles++;
            end
        end
    end

    // Mid-cycle monitor of the handshake and the fetch reports
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_req && !imem_req_o && !imem_ack_i) begin
                errors++;
                $display("Request withdrawn at %0t before memory acknowledged it", $time);
            end
            if (!prev_req && imem_req_o && imem_ack_i) begin
                errors++;
                $display("New request at %0t while ack was still high", $time);
            end
            if (prev_req && imem_req_o && imem_addr_o !== req_addr) begin
                errors++;
                $display("Request address moved at %0t while req was still high", $time);
            end
            if (imem_req_o) begin
                req_addr = imem_addr_o;
            end
            if (fetch_valid_o) begin
                check_fetch();
            end
        end
        prev_req = imem_req_o;
    end

    task automatic commit_blocks(input int k);
        int left;
        int step;
        left = k;
        if (k > outstanding.size()) begin
            errors++;
            $display("Script commits %0d blocks at %0t but only %0d are outstanding",
                     k, $time, outstanding.size());
            left = outstanding.size();
        end
        while (left > 0) begin
            step = (left > COMMIT_WIDTH) ? COMMIT_WIDTH : left;
            @(posedge clk);
            commit_i <= COMMIT_WIDTH'((1 << step) - 1);
            repeat (step) begin
                void'(outstanding.pop_front());
                commit_id = commit_id + 1'b1;
            end
            left = left - step;
        end
        @(posedge clk);
        commit_i <= '0;
    endtask

    task automatic redirect(input int id, input int pc);
        logic [FTQ_ID_W-1:0] fid;
        fid = FTQ_ID_W'(id);
        @(posedge clk);
        flush_i    <= 1'b1;
        flush_id_i <= fid;
        flush_pc_i <= ADDR_W'(pc);
        // Blocks younger than the flushed one are gone
        while (outstanding.size() > 0 && outstanding[$] != fid) begin
            void'(outstanding.pop_back());
        end
        if (outstanding.size() == 0 && fid != commit_id - 1'b1) begin
            errors++;
            $display("Flush id %0d at %0t names no outstanding block", fid, $time);
        end
        exp_pc = ADDR_W'(pc);
        exp_id = fid + 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    // Exactly n fetches, then none during the quiet window
    task automatic await_fetches(input int n, input int quiet);
        int target;
        int waited;
        target = fetch_count + n;
        waited = 0;
        while (fetch_count < target && waited < 50 * (n + 1)) begin
            @(posedge clk);
            waited++;
        end
        if (fetch_count < target) begin
            errors++;
            $display("Only %0d of %0d expected fetches arrived by %0t",
                     n - (target - fetch_count), n, $time);
        end
        repeat (quiet) @(posedge clk);
        if (fetch_count > target) begin
            mismatches++;
            $display("mismatch at %0t: %0d fetches seen, expected %0d",
                     $time, fetch_count - target + n, n);
        end
    endtask

    initial begin
        int op;
        int a;
        int b;
        $readmemh("frontend_input.txt", script);
        while (script_lines < MAX_CMDS && script[3*script_lines] != 0) begin
            script_lines++;
        end
        if (script_lines == 0) begin
            errors++;
            $display("Command script is empty or missing");
        end
        run_limit = 200 * script_lines + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (imem_req_o !== 1'b0 || fetch_valid_o !== 1'b0) begin
            mismatches++;
            $display("mismatch at %0t: req %b fetch_valid %b in reset, expected both low",
                     $time, imem_req_o, fetch_valid_o);
        end
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < script_lines; i++) begin
            op = script[3*i];
            a  = script[3*i+1];
            b  = script[3*i+2];
            case (op)
                1: ack_delay <= a;
                2: repeat (a) @(posedge clk);
                3: commit_blocks(a);
                4: redirect(a, b);
                5: await_fetches(a, b);
                default: begin
                    errors++;
                    $display("Unknown command %0d on script line %0d", op, i);
                end
            endcase
        end
        repeat (5) @(posedge clk);
        $display("Checks done: %0d mismatches, %0d other failures", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog scaled by the script length
    initial begin
        wait (run_limit > 0);
        repeat (run_limit) @(posedge clk);
        $display("Run stopped by watchdog after %0d cycles: %0d mismatches, %0d other failures",
                 run_limit, mismatches, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                                  clk,
    input  logic                                  rst,

    // Backend redirect and commit
    input  logic                                  flush_i,
    input  logic [frontend_pkg::FTQ_ID_W-1:0]     flush_id_i,
    input  logic [frontend_pkg::ADDR_W-1:0]       flush_pc_i,
    input  logic [frontend_pkg::COMMIT_WIDTH-1:0] commit_i,

    // Instruction memory
    output logic                                  imem_req_o,
    output logic [frontend_pkg::ADDR_W-1:0]       imem_addr_o,
    input  logic                                  imem_ack_i,

    // Fetched blocks
    output logic                                  fetch_valid_o,
    output logic [frontend_pkg::ADDR_W-1:0]       fetch_pc_o,
    output logic [frontend_pkg::LEN_W-1:0]        fetch_length_o,
    output logic [frontend_pkg::FTQ_ID_W-1:0]     fetch_id_o
);
    import frontend_pkg::*;

    // Predictor to queue
    logic              pred_valid;
    logic [ADDR_W-1:0] pred_start_pc;
    logic [LEN_W-1:0]  pred_length;
    logic              queue_full;

    // Queue to fetch unit
    logic                head_valid;
    logic [ADDR_W-1:0]   head_start_pc;
    logic [LEN_W-1:0]    head_length;
    logic [FTQ_ID_W-1:0] head_id;
    logic                accept;

    block_predictor u_predictor (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .flush_pc_i      (flush_pc_i),
        .queue_full_i    (queue_full),
        .pred_valid_o    (pred_valid),
        .pred_start_pc_o (pred_start_pc),
        .pred_length_o   (pred_length)
    );

    ftq u_ftq (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .flush_id_i      (flush_id_i),
        .commit_i        (commit_i),
        .pred_valid_i    (pred_valid),
        .pred_start_pc_i (pred_start_pc),
        .pred_length_i   (pred_length),
        .queue_full_o    (queue_full),
        .head_valid_o    (head_valid),
        .head_start_pc_o (head_start_pc),
        .head_length_o   (head_length),
        .head_id_o       (head_id),
        .accept_i        (accept)
    );

    fetch_unit u_fetch (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .head_valid_i    (head_valid),
        .head_start_pc_i (head_start_pc),
        .head_length_i   (head_length),
        .head_id_i       (head_id),
        .accept_o        (accept),
        .imem_req_o      (imem_req_o),
        .imem_addr_o     (imem_addr_o),
        .imem_ack_i      (imem_ack_i),
        .fetch_valid_o   (fetch_valid_o),
        .fetch_pc_o      (fetch_pc_o),
        .fetch_length_o  (fetch_length_o),
        .fetch_id_o      (fetch_id_o)
    );

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush_i,

    // Queue head
    input  logic                              head_valid_i,
    input  logic [frontend_pkg::ADDR_W-1:0]   head_start_pc_i,
    input  logic [frontend_pkg::LEN_W-1:0]    head_length_i,
    input  logic [frontend_pkg::FTQ_ID_W-1:0] head_id_i,
    output logic                              accept_o,

    // Instruction memory, four-phase req/ack
    output logic                              imem_req_o,
    output logic [frontend_pkg::ADDR_W-1:0]   imem_addr_o,
    input  logic                              imem_ack_i,

    // Fetched block report
    output logic                              fetch_valid_o,
    output logic [frontend_pkg::ADDR_W-1:0]   fetch_pc_o,
    output logic [frontend_pkg::LEN_W-1:0]    fetch_length_o,
    output logic [frontend_pkg::FTQ_ID_W-1:0] fetch_id_o
);
    import frontend_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        WAIT_LOW
    } state_t;

    state_t state_q;
    logic   kill_q;

    // Block being fetched
    logic [ADDR_W-1:0]   blk_pc_q;
    logic [LEN_W-1:0]    blk_len_q;
    logic [FTQ_ID_W-1:0] blk_id_q;

    // Take a new block only when idle and not being redirected
    assign accept_o = (state_q == IDLE) && head_valid_i && !flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            kill_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept_o) begin
                        state_q <= REQ;
                        kill_q  <= 1'b0;
                    end
                end
                REQ: begin
                    if (imem_ack_i) begin
                        state_q <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Ack usually still high here
                    state_q <= imem_ack_i ? WAIT_LOW : IDLE;
                end
                WAIT_LOW: begin
                    if (!imem_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase

            // Handshake still completes, only the report is dropped
            if (flush_i && state_q != IDLE) begin
                kill_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            blk_pc_q  <= head_start_pc_i;
            blk_len_q <= head_length_i;
            blk_id_q  <= head_id_i;
        end
    end

    assign imem_req_o  = (state_q == REQ);
    assign imem_addr_o = blk_pc_q;

    // One-cycle report right after ack was seen
    assign fetch_valid_o  = (state_q == RELEASE) && !kill_q && !flush_i;
    assign fetch_pc_o     = blk_pc_q;
    assign fetch_length_o = blk_len_q;
    assign fetch_id_o     = blk_id_q;

    // Address may not move under an open request
    assert property (@(posedge clk) disable iff (rst)
        imem_req_o |=> (!imem_req_o || $stable(imem_addr_o)))
        else $error("fetch_unit: address changed during request");

    // Memory must have returned ack low before a new request opens
    assert property (@(posedge clk) disable iff (rst)
        $rose(imem_req_o) |-> !imem_ack_i)
        else $error("fetch_unit: request raised with ack still high");

endmodule

// File: ftq.sv
`timescale 1ns/1ps

module ftq (
    input  logic                                  clk,
    input  logic                                  rst,

    // Backend redirect and commit
    input  logic                                  flush_i,
    input  logic [frontend_pkg::FTQ_ID_W-1:0]     flush_id_i,
    input  logic [frontend_pkg::COMMIT_WIDTH-1:0] commit_i,

    // Predictor side
    input  logic                                  pred_valid_i,
    input  logic [frontend_pkg::ADDR_W-1:0]       pred_start_pc_i,
    input  logic [frontend_pkg::LEN_W-1:0]        pred_length_i,
    output logic                                  queue_full_o,

    // Fetch side, accept comes back in the same cycle
    output logic                                  head_valid_o,
    output logic [frontend_pkg::ADDR_W-1:0]       head_start_pc_o,
    output logic [frontend_pkg::LEN_W-1:0]        head_length_o,
    output logic [frontend_pkg::FTQ_ID_W-1:0]     head_id_o,
    input  logic                                  accept_i
);
    import frontend_pkg::*;

    logic [COMMIT_CNT_W-1:0] commit_cnt;

    logic [FTQ_ID_W-1:0] pred_ptr_q;
    logic [FTQ_ID_W-1:0] fetch_ptr_q;
    logic [FTQ_ID_W-1:0] commit_ptr_q;
    logic [FTQ_ID_W-1:0] pred_ptr_inc;
    logic [FTQ_ID_W-1:0] flush_next_id;

    fetch_block_t queue_q [FTQ_SIZE];
    fetch_block_t queue_d [FTQ_SIZE];

    // Number of blocks retired this cycle
    always_comb begin
        commit_cnt = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_cnt = commit_cnt + COMMIT_CNT_W'(commit_i[i]);
        end
    end

    assign pred_ptr_inc  = pred_ptr_q + 1'b1;
    assign flush_next_id = flush_id_i + 1'b1;

    // One slot always stays empty, so FTQ_SIZE-1 blocks at most
    assign queue_full_o = (pred_ptr_inc == commit_ptr_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_ptr_q   <= '0;
            fetch_ptr_q  <= '0;
            commit_ptr_q <= '0;
        end else begin
            // Older blocks may still commit across a flush
            commit_ptr_q <= commit_ptr_q + FTQ_ID_W'(commit_cnt);

            if (accept_i) begin
                fetch_ptr_q <= fetch_ptr_q + 1'b1;
            end
            if (pred_valid_i) begin
                pred_ptr_q <= pred_ptr_inc;
            end

            // Restart right after the mispredicted block
            if (flush_i) begin
                fetch_ptr_q <= flush_next_id;
                pred_ptr_q  <= flush_next_id;
            end
        end
    end

    always_comb begin
        queue_d = queue_q;

        // Free the committed entries
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (COMMIT_CNT_W'(i) < commit_cnt) begin
                queue_d[commit_ptr_q + FTQ_ID_W'(i)] = '0;
            end
        end

        // New block from the predictor
        if (pred_valid_i) begin
            queue_d[pred_ptr_q].valid    = 1'b1;
            queue_d[pred_ptr_q].start_pc = pred_start_pc_i;
            queue_d[pred_ptr_q].length   = pred_length_i;
        end

        // Redirect drops everything in flight
        if (flush_i) begin
            for (int i = 0; i < FTQ_SIZE; i++) begin
                queue_d[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FTQ_SIZE; i++) begin
                queue_q[i].valid <= 1'b0;
            end
        end else begin
            queue_q <= queue_d;
        end
    end

    // Head of the fetch stream
    assign head_valid_o    = queue_q[fetch_ptr_q].valid;
    assign head_start_pc_o = queue_q[fetch_ptr_q].start_pc;
    assign head_length_o   = queue_q[fetch_ptr_q].length;
    assign head_id_o       = fetch_ptr_q;

    // Fetch unit only takes what the queue offers
    assert property (@(posedge clk) disable iff (rst)
        accept_i |-> head_valid_o)
        else $error("ftq: accept without a valid head");

endmodule

// File: block_predictor.sv
`timescale 1ns/1ps

module block_predictor (
    input  logic                            clk,
    input  logic                            rst,

    // Redirect from the backend
    input  logic                            flush_i,
    input  logic [frontend_pkg::ADDR_W-1:0] flush_pc_i,

    // Back-pressure from the queue
    input  logic                            queue_full_i,

    // Predicted block towards the queue
    output logic                            pred_valid_o,
    output logic [frontend_pkg::ADDR_W-1:0] pred_start_pc_o,
    output logic [frontend_pkg::LEN_W-1:0]  pred_length_o
);
    import frontend_pkg::*;

    logic [ADDR_W-1:0]      pc_q;
    logic [BLOCK_OFF_W-1:0] block_off;
    logic [ADDR_W-1:0]      pc_step;

    // Byte offset of the current pc inside its 16-byte block
    assign block_off = pc_q[BLOCK_OFF_W-1:0];

    // Instructions left until the block boundary
    assign pred_length_o = LEN_W'((BLOCK_BYTES - block_off) >> 2);
    assign pred_start_pc_o = pc_q;

    // Bytes covered by the emitted block
    assign pc_step = ADDR_W'(pred_length_o) << 2;

    // Nothing goes out while the queue is full or a redirect is pending
    assign pred_valid_o = !queue_full_i && !flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (flush_i) begin
            // Redirect wins over the sequential step
            pc_q <= flush_pc_i;
        end else if (pred_valid_o) begin
            pc_q <= pc_q + pc_step;
        end
    end

    // Queue must never receive a block it cannot hold
    assert property (@(posedge clk) disable iff (rst)
        !(pred_valid_o && queue_full_i))
        else $error("block_predictor: block issued while queue full");

endmodule

// File: frontend_pkg.sv
package frontend_pkg;

    // Fetch target queue geometry
    localparam int FTQ_SIZE = 8;
    localparam int FTQ_ID_W = $clog2(FTQ_SIZE);

    // Backend may retire up to this many blocks per cycle
    localparam int COMMIT_WIDTH = 2;
    // Wide enough to hold a count of 0..COMMIT_WIDTH
    localparam int COMMIT_CNT_W = $clog2(COMMIT_WIDTH + 1);

    // Address space
    localparam int ADDR_W = 32;
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000;

    // Fetch blocks end at the next 16-byte boundary
    localparam int BLOCK_BYTES = 16;
    localparam int BLOCK_OFF_W = $clog2(BLOCK_BYTES);

    // Block length counted in 4-byte instructions, 1..4
    localparam int LEN_W = 3;

    // One queue entry
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] start_pc;
        logic [LEN_W-1:0]  length;
    } fetch_block_t;

endpackage
